// ==== Makefile ====
# Verilator flow for the two-master AHB-Lite fabric

VERILATOR  ?= verilator
FILELIST   ?= ahbl_fabric.f
TB_TOP     ?= tb_ahbl_fabric
RTL_TOP    ?= ahbl_fabric_top
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Something failed
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

SOURCES := $(wildcard rtl/*.sv rtl/*.svh verif/*.sv) $(FILELIST)
SIM_BIN := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails on a non-zero exit or when the log holds the fail message
run: build
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation did not pass, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== ahbl_fabric.f ====
+incdir+rtl
rtl/ahbl_pkg.sv
rtl/fabric_map_pkg.sv
rtl/ahbl_arbiter.sv
rtl/ahbl_splitter.sv
rtl/ahbl_sram.sv
rtl/ahbl_regfile.sv
rtl/ahbl_fabric_top.sv
verif/ahbl_fabric_chk.sv
verif/tb_ahbl_fabric.sv

// ==== rtl/ahbl_arbiter.sv ====
// Strict-priority AHB-Lite arbiter, lowest port wins and losers wait in a per-port buffer
`timescale 1ns/1ps
`include "fabric_macros.svh"

module ahbl_arbiter #(
	parameter int N_PORTS = `N_MASTERS
) (
	input  logic                                              clk,
	input  logic                                              rst_n,
	// Master side, one packed field per port, port 0 in the low field
	input  logic [N_PORTS-1:0]                                src_hready,
	input  logic [N_PORTS-1:0][$bits(ahbl_pkg::htrans_e)-1:0] src_htrans,
	input  logic [N_PORTS-1:0]                                src_hwrite,
	input  logic [N_PORTS-1:0][$bits(ahbl_pkg::hsize_e)-1:0]  src_hsize,
	input  logic [N_PORTS-1:0][`W_ADDR-1:0]                   src_haddr,
	input  logic [N_PORTS-1:0][`W_DATA-1:0]                   src_hwdata,
	output logic [N_PORTS-1:0]                                src_hready_resp,
	output logic [N_PORTS-1:0]                                src_hresp,
	output logic [N_PORTS-1:0][`W_DATA-1:0]                   src_hrdata,
	// Merged bus toward the splitter
	output logic                                              dst_hready,
	output logic [`W_ADDR-1:0]                                dst_haddr,
	output logic                                              dst_hwrite,
	output ahbl_pkg::htrans_e                                 dst_htrans,
	output ahbl_pkg::hsize_e                                  dst_hsize,
	output logic [`W_DATA-1:0]                                dst_hwdata,
	input  logic                                              dst_hready_resp,
	input  ahbl_pkg::hresp_e                                  dst_hresp,
	input  logic [`W_DATA-1:0]                                dst_hrdata
);
	import ahbl_pkg::*;

	// Address phase held for a port that lost arbitration
	logic [N_PORTS-1:0] buf_valid;
	logic [`W_ADDR-1:0] buf_haddr [N_PORTS];
	logic buf_hwrite [N_PORTS];
	htrans_e buf_htrans [N_PORTS];
	hsize_e buf_hsize [N_PORTS];

	// Effective address phase per port
	logic [`W_ADDR-1:0] act_haddr [N_PORTS];
	logic act_hwrite [N_PORTS];
	htrans_e act_htrans [N_PORTS];
	hsize_e act_hsize [N_PORTS];

	logic [N_PORTS-1:0] mast_req_a;
	logic [N_PORTS-1:0] mast_gnt_a;
	logic [N_PORTS-1:0] mast_gnt_d;
	logic [N_PORTS-1:0] mast_aphase_ends;
	logic [N_PORTS-1:0] buf_wen;
	logic [N_PORTS-1:0] mast_in_dphase;

	// Buffered phase has precedence over whatever the port drives now
	always_comb begin
		for (int i = 0; i < N_PORTS; i++) begin
			if (buf_valid[i]) begin
				act_haddr[i] = buf_haddr[i];
				act_hwrite[i] = buf_hwrite[i];
				act_htrans[i] = buf_htrans[i];
				act_hsize[i] = buf_hsize[i];
			end else begin
				act_haddr[i] = src_haddr[i];
				act_hwrite[i] = src_hwrite[i];
				act_htrans[i] = htrans_e'(src_htrans[i]);
				act_hsize[i] = hsize_e'(src_hsize[i]);
			end
			mast_req_a[i] = (act_htrans[i] == NONSEQ) || (act_htrans[i] == SEQ);
		end
	end

	// Isolate the lowest set request bit, so port 0 always wins
	assign mast_gnt_a = mast_req_a & (~mast_req_a + 1'b1);

	// Bus hready follows the master that owns the current data phase
	assign dst_hready = (|mast_gnt_d) ? |(src_hready & mast_gnt_d) : 1'b1;

	// Accepted from a master but not passed on this edge
	assign mast_aphase_ends = mast_req_a & src_hready;
	assign buf_wen = mast_aphase_ends & ~(mast_gnt_a & {N_PORTS{dst_hready}});

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mast_gnt_d <= '0;
			buf_valid <= '0;
		end else begin
			if (dst_hready) begin
				mast_gnt_d <= mast_gnt_a;
			end
			// Granted buffers drain, newly stalled phases fill
			buf_valid <= (buf_valid & ~(mast_gnt_a & {N_PORTS{dst_hready}})) | buf_wen;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < N_PORTS; i++) begin
			if (buf_wen[i]) begin
				buf_haddr[i] <= src_haddr[i];
				buf_hwrite[i] <= src_hwrite[i];
				buf_htrans[i] <= htrans_e'(src_htrans[i]);
				buf_hsize[i] <= hsize_e'(src_hsize[i]);
			end
		end
	end

	// A port is busy while buffered or while it owns the slave data phase
	assign mast_in_dphase = buf_valid | mast_gnt_d;

	// Idle ports see ready, the owner sees the slave's ready
	assign src_hready_resp = ~mast_in_dphase | (mast_gnt_d & {N_PORTS{dst_hready_resp}});
	assign src_hresp = mast_gnt_d & {N_PORTS{dst_hresp == ERROR}};
	assign src_hrdata = {N_PORTS{dst_hrdata}};

	// One-hot selects, at most one port drives each output
	always_comb begin
		dst_haddr = '0;
		dst_hwrite = 1'b0;
		dst_htrans = IDLE;
		dst_hsize = BYTE;
		dst_hwdata = '0;
		for (int i = 0; i < N_PORTS; i++) begin
			if (mast_gnt_a[i]) begin
				dst_haddr = act_haddr[i];
				dst_hwrite = act_hwrite[i];
				dst_htrans = act_htrans[i];
				dst_hsize = act_hsize[i];
			end
			// Write data belongs to the data phase, so it follows the registered grant
			if (mast_gnt_d[i]) begin
				dst_hwdata = src_hwdata[i];
			end
		end
	end

endmodule

// ==== rtl/ahbl_fabric_top.sv ====
// Two-master AHB-Lite fabric: priority arbiter, address splitter, SRAM and register slaves
`timescale 1ns/1ps
`include "fabric_macros.svh"

module ahbl_fabric_top (
	input  logic                clk,
	input  logic                rst_n,
	// Master 0, highest priority
	input  logic [`W_ADDR-1:0]  m0_haddr,
	input  logic                m0_hwrite,
	input  ahbl_pkg::htrans_e   m0_htrans,
	input  ahbl_pkg::hsize_e    m0_hsize,
	input  logic [`W_DATA-1:0]  m0_hwdata,
	input  logic                m0_hready,
	output logic                m0_hready_resp,
	output logic                m0_hresp,
	output logic [`W_DATA-1:0]  m0_hrdata,
	// Master 1
	input  logic [`W_ADDR-1:0]  m1_haddr,
	input  logic                m1_hwrite,
	input  ahbl_pkg::htrans_e   m1_htrans,
	input  ahbl_pkg::hsize_e    m1_hsize,
	input  logic [`W_DATA-1:0]  m1_hwdata,
	input  logic                m1_hready,
	output logic                m1_hready_resp,
	output logic                m1_hresp,
	output logic [`W_DATA-1:0]  m1_hrdata
);
	import ahbl_pkg::*;

	// Merged bus
	logic bm_hready;
	logic [`W_ADDR-1:0] bm_haddr;
	logic bm_hwrite;
	htrans_e bm_htrans;
	hsize_e bm_hsize;
	logic [`W_DATA-1:0] bm_hwdata;
	logic bm_hready_resp;
	hresp_e bm_hresp;
	logic [`W_DATA-1:0] bm_hrdata;

	// Per-slave select and response
	logic sram_hsel;
	logic regs_hsel;
	logic [`W_DATA-1:0] sram_hrdata;
	logic sram_hready_resp;
	hresp_e sram_hresp;
	logic [`W_DATA-1:0] regs_hrdata;
	logic regs_hready_resp;
	hresp_e regs_hresp;

	// Port 0 is the low field of every packed vector
	ahbl_arbiter #(
		.N_PORTS(`N_MASTERS)
	) u_arbiter (
		.clk             (clk),
		.rst_n           (rst_n),
		.src_hready      ({m1_hready, m0_hready}),
		.src_htrans      ({m1_htrans, m0_htrans}),
		.src_hwrite      ({m1_hwrite, m0_hwrite}),
		.src_hsize       ({m1_hsize, m0_hsize}),
		.src_haddr       ({m1_haddr, m0_haddr}),
		.src_hwdata      ({m1_hwdata, m0_hwdata}),
		.src_hready_resp ({m1_hready_resp, m0_hready_resp}),
		.src_hresp       ({m1_hresp, m0_hresp}),
		.src_hrdata      ({m1_hrdata, m0_hrdata}),
		.dst_hready      (bm_hready),
		.dst_haddr       (bm_haddr),
		.dst_hwrite      (bm_hwrite),
		.dst_htrans      (bm_htrans),
		.dst_hsize       (bm_hsize),
		.dst_hwdata      (bm_hwdata),
		.dst_hready_resp (bm_hready_resp),
		.dst_hresp       (bm_hresp),
		.dst_hrdata      (bm_hrdata)
	);

	ahbl_splitter u_splitter (
		.clk              (clk),
		.rst_n            (rst_n),
		.haddr            (bm_haddr),
		.htrans           (bm_htrans),
		.hready           (bm_hready),
		.sram_hsel        (sram_hsel),
		.regs_hsel        (regs_hsel),
		.sram_hrdata      (sram_hrdata),
		.sram_hready_resp (sram_hready_resp),
		.sram_hresp       (sram_hresp),
		.regs_hrdata      (regs_hrdata),
		.regs_hready_resp (regs_hready_resp),
		.regs_hresp       (regs_hresp),
		.hrdata           (bm_hrdata),
		.hready_resp      (bm_hready_resp),
		.hresp            (bm_hresp)
	);

	// Both slaves see the same address and write data
	ahbl_sram #(
		.SRAM_WORDS(`SRAM_WORDS)
	) u_sram (
		.clk         (clk),
		.rst_n       (rst_n),
		.hsel        (sram_hsel),
		.haddr       (bm_haddr),
		.htrans      (bm_htrans),
		.hwrite      (bm_hwrite),
		.hsize       (bm_hsize),
		.hwdata      (bm_hwdata),
		.hready      (bm_hready),
		.hrdata      (sram_hrdata),
		.hready_resp (sram_hready_resp),
		.hresp       (sram_hresp)
	);

	ahbl_regfile u_regs (
		.clk         (clk),
		.rst_n       (rst_n),
		.hsel        (regs_hsel),
		.haddr       (bm_haddr),
		.htrans      (bm_htrans),
		.hwrite      (bm_hwrite),
		.hsize       (bm_hsize),
		.hwdata      (bm_hwdata),
		.hready      (bm_hready),
		.hrdata      (regs_hrdata),
		.hready_resp (regs_hready_resp),
		.hresp       (regs_hresp)
	);

endmodule

// ==== rtl/ahbl_pkg.sv ====
// AHB-Lite protocol types: transfer type, size, response, and the byte-lane strobe rule
`include "fabric_macros.svh"

package ahbl_pkg;

	// Byte lanes on the data bus
	localparam int N_LANES = `W_DATA / 8;
	localparam int W_LANE_SEL = $clog2(N_LANES);

	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_e;

	typedef enum logic [2:0] {
		BYTE = 3'd0,
		HALF = 3'd1,
		WORD = 3'd2
	} hsize_e;

	typedef enum logic {
		OKAY  = 1'b0,
		ERROR = 1'b1
	} hresp_e;

	// Lanes written by a transfer of the given size at the given byte offset
	function automatic logic [N_LANES-1:0] lane_strobe(hsize_e size, logic [W_LANE_SEL-1:0] offset);
		logic [N_LANES-1:0] strb;
		case (size)
			BYTE: strb = {{(N_LANES - 1){1'b0}}, 1'b1} << offset;
			// Halfwords are aligned, so the low offset bit is dropped
			HALF: strb = {{(N_LANES - 2){1'b0}}, 2'b11} << {offset[W_LANE_SEL-1:1], 1'b0};
			default: strb = '1;
		endcase
		return strb;
	endfunction

endpackage

// ==== rtl/ahbl_regfile.sv ====
// AHB-Lite register slave with one wait state: four scratch words and an identity word
`timescale 1ns/1ps
`include "fabric_macros.svh"

module ahbl_regfile (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                hsel,
	input  logic [`W_ADDR-1:0]  haddr,
	input  ahbl_pkg::htrans_e   htrans,
	input  logic                hwrite,
	input  ahbl_pkg::hsize_e    hsize,
	input  logic [`W_DATA-1:0]  hwdata,
	input  logic                hready,
	output logic [`W_DATA-1:0]  hrdata,
	output logic                hready_resp,
	output ahbl_pkg::hresp_e    hresp
);
	import ahbl_pkg::*;
	import fabric_map_pkg::*;

	localparam int W_OFF = $bits(reg_offset_e);
	localparam int N_SCRATCH = 4;

	// WAIT is the inserted wait state, DONE ends the data phase
	typedef enum logic [1:0] {
		RF_IDLE,
		RF_WAIT,
		RF_DONE
	} rf_state_e;

	rf_state_e state;
	logic aphase_accept;
	logic dp_commit;
	logic dp_write;
	logic [W_OFF-1:0] dp_off;
	logic [N_LANES-1:0] dp_strb;
	logic [`W_DATA-1:0] scratch [N_SCRATCH];

	assign aphase_accept = hsel && hready && ((htrans == NONSEQ) || (htrans == SEQ));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= RF_IDLE;
		end else begin
			case (state)
				RF_WAIT: state <= RF_DONE;
				// Bus is ready in IDLE and DONE, so a new phase may start
				default: state <= aphase_accept ? RF_WAIT : RF_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (aphase_accept) begin
			dp_write <= hwrite;
			dp_off <= haddr[W_OFF+W_LANE_SEL-1:W_LANE_SEL];
			dp_strb <= lane_strobe(hsize, haddr[W_LANE_SEL-1:0]);
		end
	end

	// Writes land on the final, ready cycle
	assign dp_commit = (state == RF_DONE) && dp_write;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int k = 0; k < N_SCRATCH; k++) begin
				scratch[k] <= '0;
			end
		end else if (dp_commit) begin
			for (int k = 0; k < N_SCRATCH; k++) begin
				if (dp_off == W_OFF'(REG_SCRATCH0 + k)) begin
					for (int l = 0; l < N_LANES; l++) begin
						if (dp_strb[l]) begin
							scratch[k][8*l +: 8] <= hwdata[8*l +: 8];
						end
					end
				end
			end
		end
	end

	// Identity is constant, holes in the map read as zero
	always_comb begin
		case (dp_off)
			REG_SCRATCH0: hrdata = scratch[0];
			REG_SCRATCH1: hrdata = scratch[1];
			REG_SCRATCH2: hrdata = scratch[2];
			REG_SCRATCH3: hrdata = scratch[3];
			REG_ID: hrdata = `REG_ID_VALUE;
			default: hrdata = '0;
		endcase
	end

	assign hready_resp = (state != RF_WAIT);
	assign hresp = OKAY;

endmodule

// ==== rtl/ahbl_splitter.sv ====
// AHB-Lite splitter: region decode, slave response mux and ERROR response for unmapped space
`timescale 1ns/1ps
`include "fabric_macros.svh"

module ahbl_splitter (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [`W_ADDR-1:0]   haddr,
	input  ahbl_pkg::htrans_e    htrans,
	input  logic                 hready,
	output logic                 sram_hsel,
	output logic                 regs_hsel,
	input  logic [`W_DATA-1:0]   sram_hrdata,
	input  logic                 sram_hready_resp,
	input  ahbl_pkg::hresp_e     sram_hresp,
	input  logic [`W_DATA-1:0]   regs_hrdata,
	input  logic                 regs_hready_resp,
	input  ahbl_pkg::hresp_e     regs_hresp,
	output logic [`W_DATA-1:0]   hrdata,
	output logic                 hready_resp,
	output ahbl_pkg::hresp_e     hresp
);
	import ahbl_pkg::*;
	import fabric_map_pkg::*;

	// ERROR response, first cycle not ready, second cycle ready
	typedef enum logic [1:0] {
		ERR_IDLE,
		ERR_FIRST,
		ERR_SECOND
	} err_state_e;

	slave_sel_e aphase_sel;
	slave_sel_e dphase_sel;
	err_state_e err_state;
	logic aphase_active;

	assign aphase_active = (htrans == NONSEQ) || (htrans == SEQ);
	assign aphase_sel = decode_region(haddr);

	// Selects low on IDLE so nothing is claimed after reset
	assign sram_hsel = aphase_active && (aphase_sel == SEL_SRAM);
	assign regs_hsel = aphase_active && (aphase_sel == SEL_REGS);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dphase_sel <= SEL_NONE;
			err_state <= ERR_IDLE;
		end else begin
			if (hready) begin
				dphase_sel <= aphase_active ? aphase_sel : SEL_NONE;
			end
			case (err_state)
				ERR_FIRST: err_state <= ERR_SECOND;
				// Back-to-back unmapped transfers restart from the ready cycle
				default: begin
					if (hready && aphase_active && (aphase_sel == SEL_NONE)) begin
						err_state <= ERR_FIRST;
					end else begin
						err_state <= ERR_IDLE;
					end
				end
			endcase
		end
	end

	// Response source chosen by the select captured in the address phase
	always_comb begin
		case (dphase_sel)
			SEL_SRAM: begin
				hrdata = sram_hrdata;
				hready_resp = sram_hready_resp;
				hresp = sram_hresp;
			end
			SEL_REGS: begin
				hrdata = regs_hrdata;
				hready_resp = regs_hready_resp;
				hresp = regs_hresp;
			end
			default: begin
				// Idle data phase or unmapped target
				hrdata = '0;
				hready_resp = (err_state != ERR_FIRST);
				hresp = (err_state == ERR_IDLE) ? OKAY : ERROR;
			end
		endcase
	end

endmodule

// ==== rtl/ahbl_sram.sv ====
// Zero-wait AHB-Lite SRAM slave, word storage with byte and halfword writes
`timescale 1ns/1ps
`include "fabric_macros.svh"

module ahbl_sram #(
	parameter int SRAM_WORDS = `SRAM_WORDS
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                hsel,
	input  logic [`W_ADDR-1:0]  haddr,
	input  ahbl_pkg::htrans_e   htrans,
	input  logic                hwrite,
	input  ahbl_pkg::hsize_e    hsize,
	input  logic [`W_DATA-1:0]  hwdata,
	input  logic                hready,
	output logic [`W_DATA-1:0]  hrdata,
	output logic                hready_resp,
	output ahbl_pkg::hresp_e    hresp
);
	import ahbl_pkg::*;

	localparam int W_IDX = $clog2(SRAM_WORDS);

	logic [`W_DATA-1:0] mem [SRAM_WORDS];

	// Data-phase state captured from the address phase
	logic dp_valid;
	logic dp_write;
	logic [W_IDX-1:0] dp_idx;
	logic [N_LANES-1:0] dp_strb;
	logic aphase_accept;

	assign aphase_accept = hsel && hready && ((htrans == NONSEQ) || (htrans == SEQ));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dp_valid <= 1'b0;
		end else if (hready) begin
			dp_valid <= aphase_accept;
		end
	end

	always_ff @(posedge clk) begin
		if (aphase_accept) begin
			dp_write <= hwrite;
			// Word index sits just above the byte-lane bits
			dp_idx <= haddr[W_IDX+W_LANE_SEL-1:W_LANE_SEL];
			dp_strb <= lane_strobe(hsize, haddr[W_LANE_SEL-1:0]);
		end
	end

	// Lane-wise write at the end of the single data-phase cycle
	always_ff @(posedge clk) begin
		if (dp_valid && dp_write) begin
			for (int l = 0; l < N_LANES; l++) begin
				if (dp_strb[l]) begin
					mem[dp_idx][8*l +: 8] <= hwdata[8*l +: 8];
				end
			end
		end
	end

	// Whole word on reads, the master picks its lanes
	assign hrdata = mem[dp_idx];
	assign hready_resp = 1'b1;
	assign hresp = OKAY;

endmodule

// ==== rtl/fabric_macros.svh ====
// Fabric constants: bus widths, master count, region bases, SRAM depth, identity word
`ifndef FABRIC_MACROS_SVH
`define FABRIC_MACROS_SVH

// Bus widths
`define W_ADDR 32
`define W_DATA 32

// Number of masters merged by the arbiter
`define N_MASTERS 2

// Region bases, only bits 15:12 take part in the decode
`define SRAM_BASE 32'h0000_0000
`define REG_BASE 32'h0000_1000

// SRAM depth in words
`define SRAM_WORDS 256

// Value returned by the read-only identity register
`define REG_ID_VALUE 32'h5AB1_0C01

`endif

// ==== rtl/fabric_map_pkg.sv ====
// Fabric memory map: slave-select decode and register offsets of the register block
`include "fabric_macros.svh"

package fabric_map_pkg;

	localparam logic [`W_ADDR-1:0] SRAM_BASE_ADDR = `SRAM_BASE;
	localparam logic [`W_ADDR-1:0] REG_BASE_ADDR = `REG_BASE;

	typedef enum logic [1:0] {
		SEL_NONE = 2'b00,
		SEL_SRAM = 2'b01,
		SEL_REGS = 2'b10
	} slave_sel_e;

	// Word offsets inside the 4 KB register region
	typedef enum logic [9:0] {
		REG_SCRATCH0 = 10'd0,
		REG_SCRATCH1 = 10'd1,
		REG_SCRATCH2 = 10'd2,
		REG_SCRATCH3 = 10'd3,
		REG_ID       = 10'd4
	} reg_offset_e;

	// Region lookup on bits 15:12
	function automatic slave_sel_e decode_region(logic [`W_ADDR-1:0] addr);
		if (addr[15:12] == SRAM_BASE_ADDR[15:12]) return SEL_SRAM;
		if (addr[15:12] == REG_BASE_ADDR[15:12]) return SEL_REGS;
		return SEL_NONE;
	endfunction

endpackage

// ==== verif/ahbl_fabric_chk.sv ====
// Fabric checker for the arbiter grant, merged transfer type, slave selects and ERROR response
`timescale 1ns/1ps
`include "fabric_macros.svh"

module ahbl_fabric_chk #(
	// Set on the instance bound to the arbiter
	parameter bit ON_ARBITER = 1'b0
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [`N_MASTERS-1:0]   grant,
	input  ahbl_pkg::htrans_e       htrans,
	input  logic                    sram_hsel,
	input  logic                    regs_hsel,
	input  logic                    hready_resp,
	input  ahbl_pkg::hresp_e        hresp
);
	import ahbl_pkg::*;

	if (ON_ARBITER) begin : g_arbiter
		// Data phase belongs to one master or to nobody
		grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant))
			else $error("data-phase grant %b names more than one master", grant);

		// No bursts on this fabric, so only IDLE and NONSEQ reach the slaves
		htrans_legal: assert property (@(posedge clk) disable iff (!rst_n)
			(htrans == IDLE) || (htrans == NONSEQ))
			else $error("merged bus carries transfer type %s", htrans.name());
	end else begin : g_splitter
		// Regions do not overlap
		sel_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
			!(sram_hsel && regs_hsel))
			else $error("SRAM and register selects are high together");

		// First ERROR cycle is followed by the ready ERROR cycle
		error_two_cycle: assert property (@(posedge clk) disable iff (!rst_n)
			(hresp == ERROR) && !hready_resp |=> (hresp == ERROR))
			else $error("ERROR response dropped after its first cycle");
	end

endmodule

// ==== verif/ahbl_fabric_patterns.txt ====
// master rw(1=write) address size(0 byte,1 half,2 word) hwdata expected_hresp(1=ERROR)
// master e closes a test, f closes the last one, the address column holds the test number
0 1 00000010 2 11223344 0
0 1 00000011 0 0000ab00 0
0 1 00000012 1 cdef0000 0
0 1 00000014 2 a5a5a5a5 0
0 1 00000014 1 00005678 0
0 0 00000010 2 00000000 0
0 0 00000014 2 00000000 0
e 0 00000001 0 00000000 0
1 1 00001008 2 deadbeef 0
1 1 0000100f 0 77000000 0
1 0 00001008 2 00000000 0
1 0 0000100c 2 00000000 0
1 1 00001010 2 ffffffff 0
1 0 00001010 2 00000000 0
e 0 00000002 0 00000000 0
0 0 00002000 2 00000000 1
0 1 00003004 2 12345678 1
0 1 00000020 2 0badf00d 0
0 0 00000020 2 00000000 0
e 0 00000003 0 00000000 0
0 1 00000030 2 00c0ffee 0
1 1 00000100 2 5eed5eed 0
0 0 00000030 2 00000000 0
1 0 00000100 2 00000000 0
e 0 00000004 0 00000000 0
0 1 00001000 2 13572468 0
1 1 0000100a 1 abcd0000 0
0 0 00001000 2 00000000 0
1 0 00001008 2 00000000 0
0 1 00000040 2 87654321 0
1 0 00001010 2 00000000 0
0 1 00001005 0 00009900 0
1 1 00000104 2 01020304 0
0 0 00000040 2 00000000 0
1 0 00000106 0 00000000 0
0 0 00001004 2 00000000 0
1 0 00000104 2 00000000 0
f 0 00000005 0 00000000 0

// ==== verif/tb_ahbl_fabric.sv ====
// Testbench that drives the AHB-Lite fabric from two pattern-driven masters against a memory model
`timescale 1ns/1ps
`include "fabric_macros.svh"

module tb_ahbl_fabric;
	import ahbl_pkg::*;

	localparam int N_FIELDS = 6;
	localparam int N_LINES = 48;
	localparam int WAIT_LIMIT = 40;

	logic clk;
	logic rst_n;

	// Master-side signals with index 0 as the high-priority master
	logic [`W_ADDR-1:0] mst_haddr [2];
	logic mst_hwrite [2];
	htrans_e mst_htrans [2];
	hsize_e mst_hsize [2];
	logic [`W_DATA-1:0] mst_hwdata [2];
	wire mst_hready_resp [2];
	wire mst_hresp [2];
	wire [`W_DATA-1:0] mst_hrdata [2];

	// Six pattern words per transfer line
	logic [31:0] pat [N_FIELDS*N_LINES];

	// Reference model of SRAM words and scratch registers
	logic [31:0] ref_sram [int];
	logic [31:0] ref_scratch [4];

	int checks;
	int errors;
	int xfers [2];
	time first_done [2];
	logic timed_out;

	ahbl_fabric_top dut0 (
		.clk            (clk),
		.rst_n          (rst_n),
		.m0_haddr       (mst_haddr[0]),
		.m0_hwrite      (mst_hwrite[0]),
		.m0_htrans      (mst_htrans[0]),
		.m0_hsize       (mst_hsize[0]),
		.m0_hwdata      (mst_hwdata[0]),
		.m0_hready      (mst_hready_resp[0]),
		.m0_hready_resp (mst_hready_resp[0]),
		.m0_hresp       (mst_hresp[0]),
		.m0_hrdata      (mst_hrdata[0]),
		.m1_haddr       (mst_haddr[1]),
		.m1_hwrite      (mst_hwrite[1]),
		.m1_htrans      (mst_htrans[1]),
		.m1_hsize       (mst_hsize[1]),
		.m1_hwdata      (mst_hwdata[1]),
		.m1_hready      (mst_hready_resp[1]),
		.m1_hready_resp (mst_hready_resp[1]),
		.m1_hresp       (mst_hresp[1]),
		.m1_hrdata      (mst_hrdata[1])
	);

	// Grant and transfer type are checked where the arbiter drives them
	bind ahbl_arbiter ahbl_fabric_chk #(.ON_ARBITER(1'b1)) u_arb_chk (
		.clk(clk), .rst_n(rst_n), .grant(mast_gnt_d), .htrans(dst_htrans),
		.sram_hsel(1'b0), .regs_hsel(1'b0),
		.hready_resp(dst_hready_resp), .hresp(dst_hresp)
	);
	// Selects and the ERROR sequence come from the splitter
	bind ahbl_splitter ahbl_fabric_chk #(.ON_ARBITER(1'b0)) u_split_chk (
		.clk(clk), .rst_n(rst_n), .grant('0), .htrans(htrans),
		.sram_hsel(sram_hsel), .regs_hsel(regs_hsel),
		.hready_resp(hready_resp), .hresp(hresp)
	);

	always #2 clk = ~clk;

	// Byte lanes touched by a transfer with halfwords aligned on bit 1
	function automatic logic [31:0] lane_mask(logic [31:0] addr, logic [2:0] size);
		case (size)
			3'd0: return 32'h0000_00ff << (8 * addr[1:0]);
			3'd1: return 32'h0000_ffff << (16 * addr[1]);
			default: return 32'hffff_ffff;
		endcase
	endfunction

	function automatic void model_write(logic [31:0] addr, logic [2:0] size, logic [31:0] data);
		logic [31:0] mask;
		logic [31:0] old;
		mask = lane_mask(addr, size);
		if (addr[15:12] == 4'h0) begin
			old = ref_sram.exists(addr[9:2]) ? ref_sram[addr[9:2]] : 32'h0;
			ref_sram[addr[9:2]] = (old & ~mask) | (data & mask);
		end else if (addr[15:12] == 4'h1 && addr[11:2] < 4) begin
			ref_scratch[addr[3:2]] = (ref_scratch[addr[3:2]] & ~mask) | (data & mask);
		end
		// Identity and holes ignore writes
	endfunction

	function automatic logic [31:0] model_read(logic [31:0] addr);
		if (addr[15:12] == 4'h0) begin
			return ref_sram.exists(addr[9:2]) ? ref_sram[addr[9:2]] : 32'h0;
		end
		if (addr[11:2] < 4) return ref_scratch[addr[3:2]];
		if (addr[11:2] == 4) return `REG_ID_VALUE;
		return 32'h0;
	endfunction

	function automatic string test_name(int n);
		case (n)
			1: return "SRAM byte-lane writes";
			2: return "register readback and identity";
			3: return "unmapped ERROR response";
			4: return "same-cycle arbitration";
			5: return "parallel streams with wait states";
			default: return "unnamed";
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: %s is 0x%08h, expected 0x%08h", name, got, exp);
		end
	endtask

	// Phase ends on the first rising edge with hready_resp high as sampled mid-low
	task automatic wait_ready(input int m, input string phase, output logic resp,
			output logic [31:0] rdata);
		int waited;
		logic ready;
		waited = 0;
		ready = 1'b0;
		while (!ready && !timed_out) begin
			#1;
			ready = mst_hready_resp[m];
			resp = mst_hresp[m];
			rdata = mst_hrdata[m];
			@(posedge clk);
			if (!ready) begin
				waited++;
				if (waited > WAIT_LIMIT) begin
					$display("master %0d: %s phase never saw hready_resp high", m, phase);
					timed_out = 1'b1;
				end else begin
					@(negedge clk);
				end
			end
		end
	endtask

	task automatic run_transfer(input int m, input int line);
		logic [31:0] addr;
		logic write;
		logic [2:0] size;
		logic [31:0] wdata;
		logic exp_err;
		logic resp;
		logic [31:0] rdata;
		logic [31:0] mask;
		write = pat[line*N_FIELDS+1][0];
		addr = pat[line*N_FIELDS+2];
		size = pat[line*N_FIELDS+3][2:0];
		wdata = pat[line*N_FIELDS+4];
		exp_err = pat[line*N_FIELDS+5][0];
		mask = lane_mask(addr, size);
		@(negedge clk);
		mst_haddr[m] = addr;
		mst_hwrite[m] = write;
		mst_hsize[m] = hsize_e'(size);
		mst_htrans[m] = NONSEQ;
		wait_ready(m, "address", resp, rdata);
		if (!timed_out) begin
			// Address bus goes idle in the data phase since transfers are not pipelined
			@(negedge clk);
			mst_htrans[m] = IDLE;
			mst_hwdata[m] = write ? wdata : '0;
			wait_ready(m, "data", resp, rdata);
		end
		if (!timed_out) begin
			xfers[m]++;
			if (first_done[m] == 0) first_done[m] = $time;
			check_value($sformatf("m%0d_hresp", m), {31'b0, resp}, {31'b0, exp_err});
			if (!exp_err && write) begin
				model_write(addr, size, wdata);
			end else if (!exp_err) begin
				check_value($sformatf("m%0d_hrdata", m), rdata & mask, model_read(addr) & mask);
			end
		end
	endtask

	// One master's lines up to the next end-of-test line
	task automatic run_stream(input int m, input int first);
		int i;
		i = first;
		while (i < N_LINES && pat[i*N_FIELDS] < 32'he && !timed_out) begin
			if (pat[i*N_FIELDS] == m) run_transfer(m, i);
			i++;
		end
	endtask

	initial begin
		int line;
		int test_no;
		int test_errors;
		int n_tests;
		logic last;
		clk = 1'b0;
		rst_n = 1'b0;
		for (int m = 0; m < 2; m++) begin
			mst_haddr[m] = '0;
			mst_hwrite[m] = 1'b0;
			mst_htrans[m] = IDLE;
			mst_hsize[m] = WORD;
			mst_hwdata[m] = '0;
			ref_scratch[m] = '0;
			ref_scratch[m+2] = '0;
		end
		checks = 0;
		errors = 0;
		n_tests = 0;
		timed_out = 1'b0;
		$readmemh("verif/ahbl_fabric_patterns.txt", pat);
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		line = 0;
		last = 1'b0;
		while (!last && !timed_out) begin
			test_errors = errors;
			xfers[0] = 0;
			xfers[1] = 0;
			first_done[0] = 0;
			first_done[1] = 0;
			// Both first transfers of a test start on the same falling edge
			fork
				run_stream(0, line);
				run_stream(1, line);
			join
			while (line < N_LINES && pat[line*N_FIELDS] < 32'he) line++;
			if (line >= N_LINES) begin
				$display("patterns file has no closing line");
				errors++;
				last = 1'b1;
			end else if (!timed_out) begin
				test_no = pat[line*N_FIELDS+2];
				if (xfers[0] > 0 && xfers[1] > 0) begin
					checks++;
					if (first_done[0] > first_done[1]) begin
						errors++;
						$display("test %0d: master 0 finished after master 1 in a same-cycle race",
							test_no);
					end
				end
				n_tests++;
				$display("test %0d %s: %0d transfers, %0d errors", test_no, test_name(test_no),
					xfers[0] + xfers[1], errors - test_errors);
				last = (pat[line*N_FIELDS] == 32'hf);
				line++;
			end
		end
		$display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
		if (errors == 0 && !timed_out) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule
